//--- Makefile
# Verilator flow for pcore_rf: build and run, lint, clean

TOP := rf_subsys_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): pcore_rf.f hw/*.sv test/*.sv
	verilator --binary --timing --assert -f pcore_rf.f --top-module $(TOP) -o V$(TOP)

# result taken from the log, a missing pass line counts as failure
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "simulation did not complete"; exit 1; fi

lint:
	verilator --lint-only --timing --assert -f pcore_rf.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- hw/operand_fetch.sv
// operand fetch for RV32 formats with rs1/rs2/rd in standard slots; one packet per cycle, no back-pressure
`timescale 1ns/1ps

module operand_fetch import pcore_rf_pkg::*; (
    input  logic         clk,            // core clock
    input  logic         rst_n,          // sync reset, active low

    input  logic         instr_valid_i,  // instruction strobe
    input  instr_t       instr_i,        // instruction word

    // register file read side
    output rf_addr_t     rs1_addr_o,
    output rf_addr_t     rs2_addr_o,
    input  xlen_t        rs1_data_i,
    input  xlen_t        rs2_data_i,

    output operand_pkt_t operand_o       // registered packet, one cycle later
);

    rf_addr_t rd_addr;      // destination field
    logic     valid_q;      // registered strobe
    xlen_t    rs1_data_q;
    xlen_t    rs2_data_q;
    rf_addr_t rd_addr_q;

    // field extraction, fixed RISC-V positions
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];
    assign rd_addr    = instr_i[11:7];

    // control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= instr_valid_i;
        end
    end

    // payload holds while no instruction arrives
    // read data already includes the falling-edge write of this cycle
    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            rs1_data_q <= rs1_data_i;
            rs2_data_q <= rs2_data_i;
            rd_addr_q  <= rd_addr;
        end
    end

    always_comb begin
        operand_o.valid    = valid_q;
        operand_o.rs1_data = rs1_data_q;
        operand_o.rs2_data = rs2_data_q;
        operand_o.rd_addr  = rd_addr_q;
    end

endmodule : operand_fetch

//--- hw/pcore_rf_pkg.sv
// shared widths and types for pcore_rf; RV32I only (XLEN fixed at 32, 32 integer registers)
package pcore_rf_pkg;

    // architectural sizes
    localparam int XLEN      = 32;
    localparam int RF_AWIDTH = 5;
    localparam int RF_SIZE   = 32;

    // plain vector types
    typedef logic [XLEN-1:0]      xlen_t;     // one register value
    typedef logic [RF_AWIDTH-1:0] rf_addr_t;  // register index
    typedef logic [31:0]          instr_t;    // raw instruction word

    // write request into the shared write port
    // used by writeback, debug and the arbiter output alike
    typedef struct packed {
        logic     we;     // write strobe
        rf_addr_t addr;   // destination register
        xlen_t    data;   // value to store
    } rf_wr_req_t;        // 38 bits

    // registered result of operand fetch
    typedef struct packed {
        logic     valid;     // registered instr_valid_i
        xlen_t    rs1_data;  // first source operand
        xlen_t    rs2_data;  // second source operand
        rf_addr_t rd_addr;   // destination index for later stages
    } operand_pkt_t;         // 70 bits

endpackage : pcore_rf_pkg

//--- hw/reg_file.sv
// 32x32 register file; writes land on the falling clock edge, so a same-cycle read after it sees new data
`timescale 1ns/1ps

module reg_file import pcore_rf_pkg::*; (
    input  logic       clk,         // core clock
    input  logic       rst_n,       // sync reset, active low

    // read ports, combinational
    input  rf_addr_t   rs1_addr_i,  // rs1 index
    input  rf_addr_t   rs2_addr_i,  // rs2 index
    output xlen_t      rs1_data_o,  // rs1 value
    output xlen_t      rs2_data_o,  // rs2 value

    // single write port, granted by the arbiter
    input  rf_wr_req_t wr_req_i
);

    // storage
    xlen_t regs [RF_SIZE];

    logic rs1_nonzero;
    logic rs2_nonzero;
    logic wr_en;

    assign rs1_nonzero = |rs1_addr_i;
    assign rs2_nonzero = |rs2_addr_i;
    assign wr_en       = wr_req_i.we & (|wr_req_i.addr);  // x0 writes dropped here

    // x0 is hardwired, never read from the array
    assign rs1_data_o = rs1_nonzero ? regs[rs1_addr_i] : '0;
    assign rs2_data_o = rs2_nonzero ? regs[rs2_addr_i] : '0;

    // falling-edge write, half a cycle before the next rising edge samples the reads
    always_ff @(negedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};  // whole array cleared while in reset
        end else if (wr_en) begin
            regs[wr_req_i.addr] <= wr_req_i.data;
        end
    end

endmodule : reg_file

//--- hw/rf_subsys_top.sv
// register file subsystem top; operand latency one cycle, stalls combinational in the request cycle
`timescale 1ns/1ps

module rf_subsys_top import pcore_rf_pkg::*; (
    input  logic         clk,            // core clock
    input  logic         rst_n,          // sync reset, active low

    input  logic         instr_valid_i,  // decode strobe
    input  instr_t       instr_i,        // instruction word

    input  rf_wr_req_t   core_wr_i,      // writeback peer
    input  rf_wr_req_t   dbg_wr_i,       // debug peer

    output operand_pkt_t operand_o,      // fetched operands
    output logic         core_stall_o,   // writeback must retry
    output logic         dbg_busy_o      // debug must retry
);

    // fetch <-> register file
    rf_addr_t   rs1_addr;
    rf_addr_t   rs2_addr;
    xlen_t      rs1_data;
    xlen_t      rs2_data;

    rf_wr_req_t rf_wr;   // arbitrated write

    operand_fetch i_operand_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .operand_o     (operand_o)
    );

    rf_wr_arbiter i_rf_wr_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .core_wr_i    (core_wr_i),
        .dbg_wr_i     (dbg_wr_i),
        .rf_wr_o      (rf_wr),
        .core_stall_o (core_stall_o),
        .dbg_busy_o   (dbg_busy_o)
    );

    reg_file i_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_req_i   (rf_wr)
    );

endmodule : rf_subsys_top

//--- hw/rf_wr_arbiter.sv
// two-peer write arbiter; alternating priority on contested cycles, debug wins first after reset
`timescale 1ns/1ps

module rf_wr_arbiter import pcore_rf_pkg::*; (
    input  logic       clk,           // core clock
    input  logic       rst_n,         // sync reset, active low

    input  rf_wr_req_t core_wr_i,     // writeback request
    input  rf_wr_req_t dbg_wr_i,      // debug request

    output rf_wr_req_t rf_wr_o,       // to reg_file write port
    output logic       core_stall_o,  // core lost this cycle
    output logic       dbg_busy_o     // debug lost this cycle
);

    logic dbg_prio;    // high: debug wins the next contest
    logic contested;   // both peers asking at once
    logic dbg_grant;   // select for the output mux

    assign contested = core_wr_i.we & dbg_wr_i.we;

    // debug takes the port when alone, or when contested and it holds priority
    always_comb begin
        if (contested) begin
            dbg_grant = dbg_prio;
        end else begin
            dbg_grant = dbg_wr_i.we;
        end
    end

    // addresses are not inspected, x0 is filtered in the register file
    always_comb begin
        rf_wr_o    = dbg_grant ? dbg_wr_i : core_wr_i;
        rf_wr_o.we = core_wr_i.we | dbg_wr_i.we;  // low when nobody requests
    end

    // loser sees its stall in the request cycle itself
    assign core_stall_o = contested & dbg_prio;
    assign dbg_busy_o   = contested & ~dbg_prio;

    // last-winner flop, flipped only on contested cycles
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dbg_prio <= 1'b1;
        end else if (contested) begin
            dbg_prio <= ~dbg_prio;
        end
    end

endmodule : rf_wr_arbiter

//--- pcore_rf.f
hw/pcore_rf_pkg.sv
hw/reg_file.sv
hw/rf_wr_arbiter.sv
hw/operand_fetch.sv
hw/rf_subsys_top.sv
test/rf_subsys_checker.sv
test/rf_subsys_tb.sv

//--- test/rf_subsys_checker.sv
// assertions on the write arbiter ports, sampled at the rising edge; needs a simulator with assertions on
`timescale 1ns/1ps

module rf_subsys_checker import pcore_rf_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input rf_wr_req_t core_wr_i,
    input rf_wr_req_t dbg_wr_i,
    input rf_wr_req_t rf_wr_o,
    input logic       core_stall_o,
    input logic       dbg_busy_o
);

    logic both_req;       // both peers asking this cycle
    logic contest_seen;   // some contest since reset

    assign both_req = core_wr_i.we & dbg_wr_i.we;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            contest_seen <= 1'b0;
        end else if (both_req) begin
            contest_seen <= 1'b1;
        end
    end

    // only one peer can lose
    a_stall_exclusive : assert property (@(posedge clk) !(core_stall_o && dbg_busy_o))
        else $error("core and debug stall high in the same cycle");

    a_stall_needs_contest : assert property (@(posedge clk)
        (core_stall_o || dbg_busy_o) |-> both_req)
        else $error("stall raised without both write requests");

    // port strobe follows any request
    a_port_we : assert property (@(posedge clk)
        rf_wr_o.we == (core_wr_i.we || dbg_wr_i.we))
        else $error("write port strobe differs from the request strobes");

    // reset hands the first contest to debug
    a_reset_dbg_first : assert property (@(posedge clk)
        (rst_n && both_req && !contest_seen) |-> core_stall_o)
        else $error("first contest after reset not won by debug");

endmodule : rf_subsys_checker

//--- test/rf_subsys_tb.sv
// testbench for rf_subsys_top; LFSR stimulus from a fixed seed, stops at the first error, needs timing support
`timescale 1ns/1ps

module rf_subsys_tb import pcore_rf_pkg::*; ();

    localparam int NUM_CYCLES    = 3000;
    localparam int RESET_TIMEOUT = 20;   // cycles allowed until reset release

    logic         clk;
    logic         rst_n;
    logic         instr_valid;
    instr_t       instr;
    rf_wr_req_t   core_wr;
    rf_wr_req_t   dbg_wr;
    operand_pkt_t operand;
    logic         core_stall;
    logic         dbg_busy;

    logic [31:0]  lfsr = 32'hde33;

    rf_subsys_top i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .core_wr_i     (core_wr),
        .dbg_wr_i      (dbg_wr),
        .operand_o     (operand),
        .core_stall_o  (core_stall),
        .dbg_busy_o    (dbg_busy)
    );

    bind rf_wr_arbiter rf_subsys_checker i_arb_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .core_wr_i    (core_wr_i),
        .dbg_wr_i     (dbg_wr_i),
        .rf_wr_o      (rf_wr_o),
        .core_stall_o (core_stall_o),
        .dbg_busy_o   (dbg_busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per returned bit
    function automatic logic [31:0] next_bits(input int count);
        logic [31:0] bits;
        logic        fb;
        int          i;
        bits = '0;
        for (i = 0; i < count; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_mismatch(input string name, input xlen_t got, input xlen_t exp);
        abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_stall(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            report_mismatch(name, xlen_t'(got), xlen_t'(exp));
        end
    endtask

    // payload only compared once some valid instruction has gone through
    task automatic check_operand(input operand_pkt_t got, input operand_pkt_t exp,
                                 input bit payload_known);
        if (got.valid !== exp.valid) begin
            report_mismatch("operand_o.valid", xlen_t'(got.valid), xlen_t'(exp.valid));
        end else if (payload_known) begin
            if (got.rs1_data !== exp.rs1_data) begin
                report_mismatch("operand_o.rs1_data", got.rs1_data, exp.rs1_data);
            end else if (got.rs2_data !== exp.rs2_data) begin
                report_mismatch("operand_o.rs2_data", got.rs2_data, exp.rs2_data);
            end else if (got.rd_addr !== exp.rd_addr) begin
                report_mismatch("operand_o.rd_addr", xlen_t'(got.rd_addr),
                                xlen_t'(exp.rd_addr));
            end
        end
    endtask

    task automatic wait_for_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < RESET_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            abort_run("timeout: reset was never released");
        end
    endtask

    initial begin
        xlen_t        model_regs [RF_SIZE];
        logic         last_win_dbg;   // debug took the previous contest
        rf_wr_req_t   core_req;
        rf_wr_req_t   dbg_req;
        rf_wr_req_t   win_req;
        logic         valid_draw;
        instr_t       instr_draw;
        logic         contested;
        logic         exp_core_stall;
        logic         exp_dbg_busy;
        logic         core_retry;
        logic         dbg_retry;
        operand_pkt_t exp_pkt;
        operand_pkt_t exp_next;
        bit           payload_known;
        int           n_contested;
        int           n_x0_writes;
        int           cyc;

        instr_valid <= 1'b0;
        instr       <= '0;
        core_wr     <= '0;
        dbg_wr      <= '0;
        model_regs    = '{default: '0};
        last_win_dbg  = 1'b0;          // so debug wins the first contest
        core_req      = '0;
        dbg_req       = '0;
        core_retry    = 1'b0;
        dbg_retry     = 1'b0;
        exp_pkt       = '0;
        payload_known = 1'b0;
        n_contested   = 0;
        n_x0_writes   = 0;

        wait_for_reset();

        for (cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            valid_draw = (next_bits(2) != 32'd0);   // about three in four
            instr_draw = next_bits(32);
            if (!core_retry) begin   // a stalled peer presents the same request again
                core_req.we   = 1'(next_bits(1));
                core_req.addr = rf_addr_t'(next_bits(5));
                core_req.data = next_bits(32);
            end
            if (!dbg_retry) begin
                dbg_req.we   = (next_bits(2) == 32'd3);   // sparse debug traffic
                dbg_req.addr = rf_addr_t'(next_bits(5));
                dbg_req.data = next_bits(32);
            end
            if (cyc < 4) begin   // reads right after reset, no writes yet
                valid_draw  = 1'b1;
                core_req.we = 1'b0;
                dbg_req.we  = 1'b0;
            end

            instr_valid <= valid_draw;
            instr       <= instr_draw;
            core_wr     <= core_req;
            dbg_wr      <= dbg_req;

            // arbitration and falling-edge write of this cycle
            contested      = core_req.we && dbg_req.we;
            exp_dbg_busy   = contested && last_win_dbg;
            exp_core_stall = contested && !last_win_dbg;
            win_req        = '0;
            if (contested) begin
                win_req      = last_win_dbg ? core_req : dbg_req;
                last_win_dbg = !last_win_dbg;
                n_contested++;
            end else if (core_req.we) begin
                win_req = core_req;
            end else if (dbg_req.we) begin
                win_req = dbg_req;
            end
            if (win_req.we && win_req.addr == 5'd0) begin
                n_x0_writes++;   // dropped, x0 stays zero
            end else if (win_req.we) begin
                model_regs[win_req.addr] = win_req.data;
            end
            core_retry = exp_core_stall;
            dbg_retry  = exp_dbg_busy;

            // packet expected one edge later
            exp_next       = exp_pkt;
            exp_next.valid = valid_draw;
            if (valid_draw) begin
                exp_next.rs1_data = model_regs[instr_draw[19:15]];
                exp_next.rs2_data = model_regs[instr_draw[24:20]];
                exp_next.rd_addr  = instr_draw[11:7];
            end

            @(negedge clk);
            check_stall(core_stall, exp_core_stall, "core_stall_o");
            check_stall(dbg_busy, exp_dbg_busy, "dbg_busy_o");
            check_operand(operand, exp_pkt, payload_known);
            exp_pkt = exp_next;
            if (exp_next.valid) begin
                payload_known = 1'b1;
            end
            @(posedge clk);
        end

        $display("info: %0d cycles, %0d contested, %0d writes to x0",
                 NUM_CYCLES, n_contested, n_x0_writes);
        if (n_contested == 0 || n_x0_writes == 0) begin
            abort_run("stimulus never reached a contested cycle or a write to x0");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule : rf_subsys_tb
